// File: Bender.yml
package:
  name: video_front

sources:
  - vid_pkg.sv
  - raster_counter.sv
  - video_mode.sv
  - fetch_sched.sv
  - video_top.sv
  - target: simulation
    files:
      - video_assert.sv
      - tb_video.sv

// File: fetch_sched.sv
// Video fetch scheduler
`timescale 1ns/10ps
`default_nettype none

module fetch_sched (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               c3,          // dram cycle strobe
	input  vid_pkg::vid_beam_t beam,
	input  vid_pkg::vid_win_t  win,
	input  vid_pkg::vid_mode_e render_mode,
	input  logic [20:0]        video_addr,
	input  logic [3:0]         fetch_sel,
	input  logic [1:0]         fetch_bsl,
	output logic [7:0]         cnt_col,
	output logic [8:0]         cnt_row,
	output logic               cptr,
	output vid_pkg::vid_req_t  req
);

	logic        v_win;
	logic        h_win;     // horizontal fetch window
	logic        pix_start;
	logic [8:0]  start_pos;
	logic [3:0]  fetch_cnt;
	logic        tap;
	logic        fetch_stb;
	logic        req_valid;
	logic [20:0] req_addr;
	logic [3:0]  req_sel;
	logic [1:0]  req_bsl;

	assign v_win     = (beam.vcnt >= win.vpix_beg) && (beam.vcnt < win.vpix_end);
	assign start_pos = win.hpix_beg - {4'd0, win.go_offs}; // fetch leads the pixels
	assign pix_start = v_win && (beam.hcnt == start_pos);
	assign cnt_row   = beam.vcnt - win.vpix_beg;

	// per-mode fetch rate
	always_comb begin
		case (render_mode)
			vid_pkg::M_HC: tap = &fetch_cnt[1:0]; // every 4th c3
			vid_pkg::M_XC: tap = fetch_cnt[0];    // every 2nd
			default:       tap = &fetch_cnt;      // every 16th, zx and text
		endcase
	end

	assign fetch_stb = (pix_start || (h_win && tap)) && c3;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			h_win <= 1'b0;
		end else if (pix_start) begin
			h_win <= 1'b1;
		end else if ((beam.hcnt == win.hpix_end) || beam.line_start) begin
			h_win <= 1'b0; // line start covers hpix_end past the line
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			fetch_cnt <= '0;
		end else if (pix_start) begin
			fetch_cnt <= '0;
		end else if (h_win && c3) begin
			fetch_cnt <= fetch_cnt + 4'd1;
		end
	end

	// column and buffer pointer step with each request
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cnt_col <= '0;
			cptr    <= 1'b0;
		end else if (beam.line_start) begin
			cnt_col <= '0; // zero before pix_start of the line
			cptr    <= 1'b0;
		end else if (fetch_stb) begin
			cnt_col <= cnt_col + 8'd1;
			cptr    <= ~cptr;
		end else if (pix_start) begin
			cnt_col <= '0;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			req_valid <= 1'b0;
		end else begin
			req_valid <= fetch_stb; // one cycle pulse
		end
	end

	// address and selectors of the strobe cycle
	always_ff @(posedge clk) begin
		if (fetch_stb) begin
			req_addr <= video_addr;
			req_sel  <= fetch_sel;
			req_bsl  <= fetch_bsl;
		end
	end

	always_comb begin
		req.valid = req_valid;
		req.addr  = req_addr;
		req.sel   = req_sel;
		req.bsl   = req_bsl;
	end

endmodule

`default_nettype wire

// File: raster_counter.sv
// Beam position counters
`timescale 1ns/10ps
`default_nettype none

module raster_counter #(
	parameter int H_TOTAL    = 448,
	parameter int V_TOTAL_50 = 320,
	parameter int V_TOTAL_60 = 262
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               v60hz,
	output vid_pkg::vid_beam_t beam
);

	localparam logic [8:0] H_LAST    = 9'(H_TOTAL - 1);
	localparam logic [8:0] V_LAST_50 = 9'(V_TOTAL_50 - 1);
	localparam logic [8:0] V_LAST_60 = 9'(V_TOTAL_60 - 1);

	logic [8:0] hcnt;
	logic [8:0] vcnt;
	logic       v60_frame; // rate held for the running frame
	logic [8:0] v_last;
	logic       h_wrap;
	logic       v_wrap;
	logic       line_start;
	logic       frame_start;

	assign v_last = v60_frame ? V_LAST_60 : V_LAST_50;
	assign h_wrap = (hcnt == H_LAST);
	assign v_wrap = (vcnt == v_last);

	assign line_start  = (hcnt == 9'd0);
	assign frame_start = line_start && (vcnt == 9'd0);

	// horizontal, one step per clk
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			hcnt <= '0;
		end else if (h_wrap) begin
			hcnt <= '0;
		end else begin
			hcnt <= hcnt + 9'd1;
		end
	end

	// vertical steps on line wrap
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			vcnt <= '0;
		end else if (h_wrap) begin
			if (v_wrap) begin
				vcnt <= '0; // frame done
			end else begin
				vcnt <= vcnt + 9'd1;
			end
		end
	end

	// v60hz only taken at frame start
	// so a frame keeps its length
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			v60_frame <= 1'b0;
		end else if (frame_start) begin
			v60_frame <= v60hz;
		end
	end

	always_comb begin
		beam.hcnt        = hcnt;
		beam.vcnt        = vcnt;
		beam.line_start  = line_start;
		beam.frame_start = frame_start;
	end

endmodule

`default_nettype wire

// File: tb_video.sv
// Video front end testbench
`timescale 1ns/10ps
`default_nettype none

module tb_video;

	localparam int H_TOTAL    = 448;
	localparam int V_TOTAL_50 = 320;
	localparam int V_TOTAL_60 = 262;
	localparam int PERIOD     = 8;
	localparam int C3_DIV     = 4;
	localparam int FETCH_GAP  = 16 * C3_DIV; // zx and text, one fetch per 16 c3
	localparam int WD_NS      = (3 * H_TOTAL * V_TOTAL_50 + 4000) * PERIOD;

	// expected tables, by rres then by vmod
	localparam int T_HBEG[4] = '{140, 108, 108, 88};
	localparam int T_HEND[4] = '{396, 428, 428, 448};
	localparam int T_XT[4]   = '{34, 42, 42, 47};
	localparam int T_VB50[4] = '{80, 76, 56, 32};
	localparam int T_VB60[4] = '{46, 42, 22, 22};
	localparam int T_VE50[4] = '{272, 276, 296, 320};
	localparam int T_VE60[4] = '{238, 242, 262, 262};
	localparam int T_GO[4]   = '{18, 6, 4, 10};
	localparam logic [4:0] T_BW[4] = '{5'b11_001, 5'b01_001, 5'b00_001, 5'b11_100};
	localparam logic [3:0] T_TSEL[4] = '{4'b0010, 4'b0011, 4'b1100, 4'b0001};

	logic clk = 1'b0;
	logic rst_n, c3, v60hz;
	logic [7:0] vconf, vpage;
	logic [8:0] gx_offs;
	logic [15:0] txt_char;
	vid_pkg::vid_req_t req;
	vid_pkg::vid_win_t win;
	vid_pkg::vid_bw_t video_bw;
	logic tv_hires, vga_hires, nogfx;
	vid_pkg::vid_mode_e render_mode;
	logic [9:0] x_offs_mode;
	logic [31:0] lfsr_state = 32'h4a2b_9a08;
	int neg_cnt = 0;

	video_top #(.H_TOTAL(H_TOTAL), .V_TOTAL_50(V_TOTAL_50), .V_TOTAL_60(V_TOTAL_60)) UUT (
		.clk(clk), .rst_n(rst_n), .c3(c3), .vconf(vconf), .vpage(vpage), .v60hz(v60hz),
		.gx_offs(gx_offs), .txt_char(txt_char), .req(req), .win(win), .video_bw(video_bw),
		.tv_hires(tv_hires), .vga_hires(vga_hires), .render_mode(render_mode),
		.nogfx(nogfx), .x_offs_mode(x_offs_mode)
	);

	bind video_top video_assert u_assert (.clk(clk), .rst_n(rst_n), .c3(c3), .req(req),
		.beam(beam), .win(win), .vga_hires(vga_hires));

	always #(PERIOD / 2) clk = ~clk;

	// c3 lands on hcnt 2 mod 4, as do the zx and text fetch starts
	always @(negedge clk) begin
		neg_cnt = neg_cnt + 1;
		c3 = (neg_cnt % C3_DIV == 0);
	end

	task automatic stop_run();
		$display("TESTS FAILED");
		$fatal(1, "run stopped");
	endtask

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state); // one step per bit
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	task automatic check_win(input string name, input vid_pkg::vid_win_t e, a);
		if (e !== a) begin
			$display("FAILED at %0t: %s expected %h got %h", $time, name, e, a);
			stop_run();
		end
	endtask

	task automatic check_req(input string name, input vid_pkg::vid_req_t e, a);
		if (e !== a) begin
			$display("FAILED at %0t: %s expected %h got %h", $time, name, e, a);
			stop_run();
		end
	endtask

	task automatic check_bw(input string name, input vid_pkg::vid_bw_t e, a);
		if (e !== a) begin
			$display("FAILED at %0t: %s expected %b got %b", $time, name, e, a);
			stop_run();
		end
	endtask

	task automatic check_mode(input string name, input vid_pkg::vid_mode_e e, a);
		if (e !== a) begin
			$display("FAILED at %0t: %s expected %0d got %0d", $time, name, e, a);
			stop_run();
		end
	endtask

	task automatic check_bit(input string name, input logic e, a);
		if (e !== a) begin
			$display("FAILED at %0t: %s expected %b got %b", $time, name, e, a);
			stop_run();
		end
	endtask

	task automatic check_vec(input string name, input logic [9:0] e, a);
		if (e !== a) begin
			$display("FAILED at %0t: %s expected %h got %h", $time, name, e, a);
			stop_run();
		end
	endtask

	function automatic vid_pkg::vid_win_t win_expect(input int r, m, input logic f);
		vid_pkg::vid_win_t w;
		w.hpix_beg = 9'(T_HBEG[r]);
		w.hpix_end = 9'(T_HEND[r]);
		w.vpix_beg = 9'(f ? T_VB60[r] : T_VB50[r]);
		w.vpix_end = 9'(f ? T_VE60[r] : T_VE50[r]);
		w.x_tiles  = 6'(T_XT[r]);
		w.go_offs  = 5'(T_GO[m]);
		return w;
	endfunction

	// zx: gfx on even columns, attr block at 0x1800 on odd ones
	function automatic logic [20:0] zx_addr(input logic [7:0] pg, input logic [8:0] row,
		input logic [7:0] col);
		logic [11:0] ofs;
		ofs = col[0] ? {3'b110, row[7:3], col[4:1]}
			: {row[7:6], row[2:0], row[5:3], col[4:1]};
		return {pg, 1'b0, ofs};
	endfunction

	function automatic logic [20:0] txt_addr(input logic [7:0] pg, input logic [8:0] row,
		input logic [7:0] col, input logic [15:0] tc);
		case (col[1:0])
			2'd0: return {pg[7:1], pg[0], row[8:3], 1'b0, col[7:2]};
			2'd1: return {pg[7:1], pg[0], row[8:3], 1'b1, col[7:2]};
			2'd2: return {pg[7:1], ~pg[0], 3'b000, tc[7:0], row[2:1]};
			default: return {pg[7:1], ~pg[0], 3'b000, tc[15:8], row[2:1]};
		endcase
	endfunction

	task automatic wait_pos(input int v, h); // v < 0 means any line
		for (int i = 0; i <= (V_TOTAL_50 + 1) * H_TOTAL; i++) begin
			@(negedge clk);
			if (UUT.beam.hcnt == h && (v < 0 || UUT.beam.vcnt == v)) return;
		end
		$display("timeout waiting for beam line %0d column %0d", v, h);
		stop_run();
	endtask

	task automatic get_req(output vid_pkg::vid_req_t r, output int h);
		for (int i = 0; i < 2 * H_TOTAL; i++) begin
			@(negedge clk);
			if (req.valid) begin
				r = req;
				h = UUT.beam.hcnt;
				return;
			end
		end
		$display("timeout, no fetch request within two lines");
		stop_run();
	endtask

	task automatic test_static_decode();
		logic [31:0] rb;
		for (int r = 0; r < 4; r++)
			for (int m = 0; m < 4; m++)
				for (int f = 0; f < 2; f++) begin
					rand_bits(1, rb);
					@(negedge clk);
					vconf = {2'(r), rb[0], 3'b000, 2'(m)};
					v60hz = f[0];
					#1;
					check_win("win", win_expect(r, m, f[0]), win);
					check_bw("video_bw", T_BW[m], video_bw);
					check_mode("render_mode", vid_pkg::vid_mode_e'(m), render_mode);
					check_bit("tv_hires", m == 3, tv_hires);
					check_bit("nogfx", rb[0], nogfx);
				end
		@(negedge clk);
		v60hz = 1'b0;
	endtask

	task automatic test_x_offs();
		logic [31:0] rv;
		logic [9:0] e;
		for (int n = 0; n < 8; n++) begin
			rand_bits(9, rv);
			for (int m = 0; m < 4; m++) begin
				@(negedge clk);
				vconf = {6'b110000, 2'(m)};
				gx_offs = rv[8:0];
				#1;
				e = (m == 2) ? {rv[8:1], 1'b0, rv[0]} : {1'b0, rv[8:1], rv[0]}; // x2 / half
				check_vec("x_offs_mode", e, x_offs_mode);
			end
		end
	endtask

	task automatic test_vga_hires();
		@(negedge clk);
		vconf = 8'hc0;
		wait_pos(-1, 0);
		wait_pos(-1, H_TOTAL / 2);
		check_bit("vga_hires", 1'b0, vga_hires);
		vconf = 8'hc3; // text, mid-line
		do begin
			@(negedge clk);
			check_bit("vga_hires", 1'b0, vga_hires);
		end while (!UUT.beam.line_start);
		@(negedge clk);
		check_bit("tv_hires", 1'b1, tv_hires);
		check_bit("vga_hires", 1'b1, vga_hires);
	endtask

	task automatic test_fetch(input logic [1:0] m, input int row);
		vid_pkg::vid_req_t r, e;
		logic [31:0] rv;
		int h, h_exp;
		wait_pos(T_VB50[3] + row - 1, 0);
		vconf = {6'b110000, m};
		rand_bits(8, rv);
		vpage = rv[7:0];
		rand_bits(16, rv);
		txt_char = rv[15:0];
		// run out the line above the tested row
		do begin
			@(negedge clk);
			if (row == 0) begin // line above the window stays quiet
				check_bit("req.valid", 1'b0, req.valid);
			end
		end while (UUT.beam.vcnt == T_VB50[3] + row - 1);
		h_exp = T_HBEG[3] - T_GO[m] + 1;
		for (int i = 0; i < 4; i++) begin
			get_req(r, h);
			if (h != h_exp) begin
				$display("request %0d arrived at column %0d instead of %0d", i, h, h_exp);
				stop_run();
			end
			h_exp = h + FETCH_GAP;
			e.valid = 1'b1;
			if (m == 2'd0) begin
				e.addr = zx_addr(vpage, 9'(row), 8'(i));
				e.sel  = {~i[0], ~i[0], i[0], i[0]};
				e.bsl  = 2'b10;
			end else begin
				e.addr = txt_addr(vpage, 9'(row), 8'(i), txt_char);
				e.sel  = T_TSEL[i];
				e.bsl  = (i == 1 || i == 2) ? 2'b10 : {2{row[0]}};
			end
			check_req("req", e, r);
		end
	endtask

	task automatic test_reset_blank();
		@(negedge clk);
		vconf = 8'hc0;
		wait_pos(0, 0);
		while (UUT.beam.vcnt < T_VB50[3]) begin
			check_bit("req.valid", 1'b0, req.valid);
			@(negedge clk);
		end
		rst_n = 1'b0;
		repeat (10) begin
			@(negedge clk);
			check_bit("req.valid", 1'b0, req.valid);
		end
		rst_n = 1'b1;
		repeat (4) begin
			@(negedge clk);
			check_bit("req.valid", 1'b0, req.valid);
		end
	endtask

	initial begin
		#(WD_NS);
		$display("watchdog expired, the tests ran too long");
		stop_run();
	end

	initial begin
		rst_n = 1'b0;
		c3 = 1'b0;
		vconf = 8'h00;
		vpage = 8'h00;
		v60hz = 1'b0;
		gx_offs = '0;
		txt_char = '0;
		repeat (10) @(negedge clk);
		rst_n = 1'b1;
		test_static_decode();
		test_x_offs();
		test_vga_hires();
		test_fetch(2'd0, 0);  // zx, first window line
		test_fetch(2'd3, 13); // text, odd row
		test_reset_blank();
		$display("TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: vid_pkg.sv
// Video front end shared types
`default_nettype none

package vid_pkg;

	// mode field vconf[1:0], render mode uses the same codes
	typedef enum logic [1:0] {
		M_ZX = 2'd0, // zx screen, gfx + attr
		M_HC = 2'd1, // 16 colour
		M_XC = 2'd2, // 256 colour
		M_TX = 2'd3  // text
	} vid_mode_e;

	// raster window and fetch start offset
	typedef struct packed {
		logic [8:0] hpix_beg;
		logic [8:0] hpix_end;
		logic [8:0] vpix_beg;
		logic [8:0] vpix_end;
		logic [5:0] x_tiles;
		logic [4:0] go_offs; // fetch lead before first pixel
	} vid_win_t;

	typedef struct packed {
		logic [8:0] hcnt;
		logic [8:0] vcnt;
		logic       line_start;  // hcnt == 0
		logic       frame_start; // hcnt == 0 && vcnt == 0
	} vid_beam_t;

	// one dram read request, 28 bits
	typedef struct packed {
		logic        valid;
		logic [20:0] addr; // dram word address
		logic [3:0]  sel;  // byte lane selectors for the render side
		logic [1:0]  bsl;
	} vid_req_t;

	typedef struct packed {
		logic [1:0] total; // cycle class
		logic [2:0] need;  // one-hot count of used cycles
	} vid_bw_t;

	localparam logic [1:0] BW2 = 2'b00; // 2 cycles
	localparam logic [1:0] BW4 = 2'b01; // 4 cycles
	localparam logic [1:0] BW8 = 2'b11; // 8 cycles
	localparam logic [2:0] BU1 = 3'b001;
	localparam logic [2:0] BU4 = 3'b100;

	// raster tables by rres
	localparam logic [8:0] HPIX_BEG_TAB [4] = '{9'd140, 9'd108, 9'd108, 9'd88};
	localparam logic [8:0] HPIX_END_TAB [4] = '{9'd396, 9'd428, 9'd428, 9'd448};
	localparam logic [5:0] X_TILES_TAB  [4] = '{6'd34, 6'd42, 6'd42, 6'd47};
	localparam logic [8:0] VPIX_BEG_50  [4] = '{9'd80, 9'd76, 9'd56, 9'd32};
	localparam logic [8:0] VPIX_BEG_60  [4] = '{9'd46, 9'd42, 9'd22, 9'd22};
	localparam logic [8:0] VPIX_END_50  [4] = '{9'd272, 9'd276, 9'd296, 9'd320};
	localparam logic [8:0] VPIX_END_60  [4] = '{9'd238, 9'd242, 9'd262, 9'd262};

	// mode tables by vmod
	localparam logic [4:0] GO_OFFS_TAB [4] = '{5'd18, 5'd6, 5'd4, 5'd10};
	localparam vid_bw_t BW_TAB [4] = '{
		'{BW8, BU1}, // 1 of 8, zx
		'{BW4, BU1}, // 1 of 4, 16c
		'{BW2, BU1}, // 1 of 2, 256c
		'{BW8, BU4}  // 4 of 8, text
	};

	// text selectors by phase cnt_col[1:0]
	// column already stepped when the data lands
	localparam logic [3:0] TXT_SEL_TAB [4] = '{4'b0010, 4'b0011, 4'b1100, 4'b0001};

endpackage

`default_nettype wire

// File: video_assert.sv
// Video front end assertions
`timescale 1ns/10ps
`default_nettype none

module video_assert (
	input logic               clk,
	input logic               rst_n,
	input logic               c3,
	input vid_pkg::vid_req_t  req,
	input vid_pkg::vid_beam_t beam,
	input vid_pkg::vid_win_t  win,
	input logic               vga_hires
);

	logic in_vwin;

	assign in_vwin = (beam.vcnt >= win.vpix_beg) && (beam.vcnt < win.vpix_end);

	// request is the registered strobe, strobe needs c3
	req_after_c3: assert property (@(posedge clk) disable iff (!rst_n)
		req.valid |-> $past(c3))
		else $error("req.valid without c3 in the cycle before");

	req_in_window: assert property (@(posedge clk) disable iff (!rst_n)
		req.valid |-> $past(in_vwin))
		else $error("req.valid outside the vertical window");

	// hires flag only moves at a line boundary
	hires_at_line: assert property (@(posedge clk) disable iff (!rst_n)
		$changed(vga_hires) |-> $past(beam.line_start))
		else $error("vga_hires changed away from line_start");

	reset_quiet: assert property (@(posedge clk)
		$rose(rst_n) |-> (!req.valid && !vga_hires))
		else $error("control outputs not low after reset");

endmodule

`default_nettype wire

// File: video_mode.sv
// Video mode decoder
`timescale 1ns/10ps
`default_nettype none

module video_mode (
	input  logic               clk,
	input  logic               rst_n,
	input  logic [7:0]         vconf,
	input  logic [7:0]         vpage,
	input  logic               v60hz,
	input  logic [8:0]         gx_offs,
	input  logic [15:0]        txt_char, // char code pair from the last fetch
	input  vid_pkg::vid_beam_t beam,
	input  logic [7:0]         cnt_col,
	input  logic [8:0]         cnt_row,
	input  logic               cptr,
	output vid_pkg::vid_win_t  win,
	output logic [3:0]         fetch_sel,
	output logic [1:0]         fetch_bsl,
	output vid_pkg::vid_mode_e render_mode,
	output vid_pkg::vid_bw_t   video_bw,
	output logic [20:0]        video_addr,
	output logic               tv_hires,
	output logic               vga_hires,
	output logic               nogfx,
	output logic [9:0]         x_offs_mode
);

	vid_pkg::vid_mode_e vmod;
	logic [1:0]         rres;
	logic [1:0]         phase; // text fetch phase

	logic [11:0] zx_gfx;
	logic [11:0] zx_atr;
	logic [20:0] addr_zx;
	logic [20:0] addr_hc;
	logic [20:0] addr_xc;
	logic [13:0] tx_low;
	logic [20:0] addr_tx;

	assign vmod  = vid_pkg::vid_mode_e'(vconf[1:0]);
	assign rres  = vconf[7:6];
	assign nogfx = vconf[5];
	assign phase = cnt_col[1:0];

	// raster window
	always_comb begin
		win.hpix_beg = vid_pkg::HPIX_BEG_TAB[rres];
		win.hpix_end = vid_pkg::HPIX_END_TAB[rres];
		win.x_tiles  = vid_pkg::X_TILES_TAB[rres];
		if (v60hz) begin
			win.vpix_beg = vid_pkg::VPIX_BEG_60[rres];
			win.vpix_end = vid_pkg::VPIX_END_60[rres];
		end else begin
			win.vpix_beg = vid_pkg::VPIX_BEG_50[rres];
			win.vpix_end = vid_pkg::VPIX_END_50[rres];
		end
		win.go_offs = vid_pkg::GO_OFFS_TAB[vmod]; // depends on mode, not rres
	end

	assign render_mode = vmod;
	assign video_bw    = vid_pkg::BW_TAB[vmod];
	assign tv_hires    = (vmod == vid_pkg::M_TX); // only text runs at the fast rate

	// takes effect from the next line only
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			vga_hires <= 1'b0;
		end else if (beam.line_start) begin
			vga_hires <= tv_hires;
		end
	end

	// 256c scrolls in double steps, others in half steps
	always_comb begin
		if (vmod == vid_pkg::M_XC) begin
			x_offs_mode = {gx_offs[8:1], 1'b0, gx_offs[0]};
		end else begin
			x_offs_mode = {1'b0, gx_offs[8:1], gx_offs[0]};
		end
	end

	// fetch selectors
	always_comb begin
		case (vmod)
			vid_pkg::M_ZX: fetch_sel = {~cptr, ~cptr, cptr, cptr}; // gfx / attr halves
			vid_pkg::M_HC: fetch_sel = {~cptr, ~cptr, 2'b11};
			vid_pkg::M_XC: fetch_sel = {~cptr, ~cptr, 2'b11};
			default:       fetch_sel = vid_pkg::TXT_SEL_TAB[phase];
		endcase
	end

	always_comb begin
		fetch_bsl = 2'b10;
		if (vmod == vid_pkg::M_TX) begin
			case (phase)
				2'd1, 2'd2: fetch_bsl = 2'b10;           // char, attr
				default:    fetch_bsl = {2{cnt_row[0]}}; // glyph bytes by odd row
			endcase
		end
	end

	// zx screen layout, thirds of 64 lines
	assign zx_gfx  = {cnt_row[7:6], cnt_row[2:0], cnt_row[5:3], cnt_col[4:1]};
	assign zx_atr  = {3'b110, cnt_row[7:3], cnt_col[4:1]}; // attr area at 0x1800
	assign addr_zx = {vpage, 1'b0, cnt_col[0] ? zx_atr : zx_gfx};

	// linear bitmaps
	assign addr_hc = {vpage[7:3], cnt_row, cnt_col[6:0]};
	assign addr_xc = {vpage[7:4], cnt_row, cnt_col};

	// text, 8 rows per char line
	always_comb begin
		case (phase)
			2'd0:    tx_low = {vpage[0], cnt_row[8:3], 1'b0, cnt_col[7:2]};  // char codes
			2'd1:    tx_low = {vpage[0], cnt_row[8:3], 1'b1, cnt_col[7:2]};  // attributes
			2'd2:    tx_low = {~vpage[0], 3'b000, txt_char[7:0], cnt_row[2:1]};  // gfx0
			default: tx_low = {~vpage[0], 3'b000, txt_char[15:8], cnt_row[2:1]}; // gfx1
		endcase
	end

	assign addr_tx = {vpage[7:1], tx_low};

	always_comb begin
		case (vmod)
			vid_pkg::M_ZX: video_addr = addr_zx;
			vid_pkg::M_HC: video_addr = addr_hc;
			vid_pkg::M_XC: video_addr = addr_xc;
			default:       video_addr = addr_tx;
		endcase
	end

endmodule

`default_nettype wire

// File: video_top.sv
// Video front end top
`timescale 1ns/10ps
`default_nettype none

module video_top #(
	parameter int H_TOTAL    = 448,
	parameter int V_TOTAL_50 = 320,
	parameter int V_TOTAL_60 = 262
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               c3,
	input  logic [7:0]         vconf,
	input  logic [7:0]         vpage,
	input  logic               v60hz,
	input  logic [8:0]         gx_offs,
	input  logic [15:0]        txt_char,
	output vid_pkg::vid_req_t  req,
	output vid_pkg::vid_win_t  win,
	output vid_pkg::vid_bw_t   video_bw,
	output logic               tv_hires,
	output logic               vga_hires,
	output vid_pkg::vid_mode_e render_mode,
	output logic               nogfx,
	output logic [9:0]         x_offs_mode
);

	vid_pkg::vid_beam_t beam;
	logic [3:0]         fetch_sel;
	logic [1:0]         fetch_bsl;
	logic [20:0]        video_addr;
	logic [7:0]         cnt_col;
	logic [8:0]         cnt_row;
	logic               cptr;

	raster_counter #(
		.H_TOTAL   (H_TOTAL),
		.V_TOTAL_50(V_TOTAL_50),
		.V_TOTAL_60(V_TOTAL_60)
	) u_raster (
		.clk  (clk),
		.rst_n(rst_n),
		.v60hz(v60hz),
		.beam (beam)
	);

	video_mode u_mode (
		.clk        (clk),
		.rst_n      (rst_n),
		.vconf      (vconf),
		.vpage      (vpage),
		.v60hz      (v60hz),
		.gx_offs    (gx_offs),
		.txt_char   (txt_char),
		.beam       (beam),
		.cnt_col    (cnt_col),
		.cnt_row    (cnt_row),
		.cptr       (cptr),
		.win        (win),
		.fetch_sel  (fetch_sel),
		.fetch_bsl  (fetch_bsl),
		.render_mode(render_mode),
		.video_bw   (video_bw),
		.video_addr (video_addr),
		.tv_hires   (tv_hires),
		.vga_hires  (vga_hires),
		.nogfx      (nogfx),
		.x_offs_mode(x_offs_mode)
	);

	// counters loop back into the address decode
	fetch_sched u_sched (
		.clk        (clk),
		.rst_n      (rst_n),
		.c3         (c3),
		.beam       (beam),
		.win        (win),
		.render_mode(render_mode),
		.video_addr (video_addr),
		.fetch_sel  (fetch_sel),
		.fetch_bsl  (fetch_bsl),
		.cnt_col    (cnt_col),
		.cnt_row    (cnt_row),
		.cptr       (cptr),
		.req        (req)
	);

endmodule

`default_nettype wire

// File: vlog.f
vid_pkg.sv
raster_counter.sv
video_mode.sv
fetch_sched.sv
video_top.sv
video_assert.sv
tb_video.sv
